// File: all.f
source/pinballGeomPkg.sv
source/pinballTypesPkg.sv
source/frameTicker.sv
source/flipperController.sv
source/springPlunger.sv
source/collisionDetector.sv
source/ballController.sv
source/pinballTop.sv
bench/pinballTb.sv

// File: bench/pinballTb.sv
`timescale 1ns/1ns

module pinballTb import pinballGeomPkg::*, pinballTypesPkg::*; ();

localparam int FRAME_LEN = 64;
localparam int GRAVITY = 8;
localparam int STEP = 6;
localparam int FALL_FRAMES = 80;	// no keys, ball drops onto the flipper
localparam int TOTAL_FRAMES = 600;

logic clk = 1'b0;
logic resetN, pause, resetLevel, flipperLeftKey, flipperRightKey, launchKey;
ballPos ball;
pixelCoord flipperX;
logic startOfFrame;

int errorCount = 0;
int checkCount = 0;
int launchCount = 0;
int sinceFrame = 0;	// clocks since the last strobe
logic timedOut = 1'b0;

// reference state
int mPosX, mPosY, mVx, mVy;	// fixed point
int mFx, mFs, mCharge;
plungerState mState;
logic mTop, mLeft, mRight, mFlip, mObs, mSpr;
logic [3:0] mEdge;	// registered contacts

pinballTop #(.FRAME_CYCLES(FRAME_LEN), .GRAVITY(GRAVITY), .FLIPPER_STEP(STEP)) uut (
	.clk(clk), .resetN(resetN), .pause(pause), .resetLevel(resetLevel),
	.flipperLeftKey(flipperLeftKey), .flipperRightKey(flipperRightKey),
	.launchKey(launchKey), .ball(ball), .flipperX(flipperX), .startOfFrame(startOfFrame)
);

always #2 clk = ~clk;

task automatic compareValues(input string name, input int expected, input int actual);
	checkCount++;
	if (expected !== actual) begin
		errorCount++;
		$display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

task automatic waitFrame();
	int cycles;
	cycles = 0;
	while (!startOfFrame && cycles < 2 * FRAME_LEN) begin
		@(negedge clk);
		cycles++;
	end
	if (!startOfFrame) begin
		$display("timeout: no startOfFrame within %0d cycles", 2 * FRAME_LEN);
		errorCount++;
		timedOut = 1'b1;
	end
endtask

function automatic int toPixel(input int fixedPos);
	pixelCoord p;
	p = pixelCoord'(fixedPos / FIXED_POINT_MULTIPLIER);	// 11-bit screen value
	return int'(p);
endfunction

function automatic logic boxOverlap(input int bx, input int by, input int l, input int t,
		input int r, input int b);
	return (bx < r) && (l < bx + BALL_SIZE) && (by < b) && (t < by + BALL_SIZE);
endfunction

// one-hot ball side with the least penetration, bottom first on a tie
function automatic logic [3:0] nearestSide(input int bx, input int by, input int l,
		input int t, input int r, input int b);
	int depth [4];
	int pick;
	depth[0] = by + BALL_SIZE - t;
	depth[1] = bx + BALL_SIZE - l;
	depth[2] = b - by;
	depth[3] = r - bx;
	pick = 0;
	for (int i = 1; i < 4; i++) begin
		if (depth[i] < depth[pick]) begin
			pick = i;
		end
	end
	return 4'b0001 << pick;
endfunction

// strobe spacing, counted from reset release or the previous strobe
always @(negedge clk) begin : framePeriod
	if (!resetN) begin
		sinceFrame = 0;
	end
	else begin
		sinceFrame++;
		if (startOfFrame) begin
			compareValues("frame period", FRAME_LEN, sinceFrame);
			sinceFrame = 0;
		end
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model, one step per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge clk or negedge resetN) begin : refModel
	int nextVx, nextVy, bx, by, step;
	logic sided, launched;
	if (!resetN) begin
		mPosX = BALL_INITIAL_X * FIXED_POINT_MULTIPLIER;
		mPosY = BALL_INITIAL_Y * FIXED_POINT_MULTIPLIER;
		mVx = 0;
		mVy = 0;
		mFx = FLIPPER_INITIAL_X;
		mFs = 0;
		mState = idle;
		mCharge = 0;
		{mTop, mLeft, mRight, mFlip, mObs, mSpr, mEdge} = '0;
	end
	else begin
		sided = mObs || mSpr;
		nextVx = mVx;
		nextVy = mVy;
		launched = 1'b0;
		if (((mTop || (sided && mEdge[2])) && mVy < 0) ||
				((mFlip || (sided && mEdge[0])) && mVy > 0)) begin
			nextVy = -mVy;
		end
		else if (mState == firing && mSpr && mEdge[0]) begin
			nextVy = mVy - mCharge * SPRING_GAIN;	// launch from the cap
			launched = 1'b1;
		end
		if (((mLeft || (sided && mEdge[3])) && mVx < 0) ||
				((mRight || (sided && mEdge[1])) && mVx > 0)) begin
			nextVx = -mVx;
		end
		else if (mFlip && mVy > 0) begin
			nextVx = mVx + mFs;
		end
		// contacts of the positions before this edge
		bx = toPixel(mPosX);
		by = toPixel(mPosY);
		mTop = (by <= 0);
		mLeft = (bx <= 0);
		mRight = (bx + BALL_SIZE >= SCREEN_WIDTH);
		mFlip = boxOverlap(bx, by, mFx, FLIPPER_Y, mFx + FLIPPER_WIDTH,
			FLIPPER_Y + FLIPPER_HEIGHT);
		mObs = boxOverlap(bx, by, OBSTACLE_X, OBSTACLE_Y, OBSTACLE_X + OBSTACLE_SIZE,
			OBSTACLE_Y + OBSTACLE_SIZE);
		mSpr = boxOverlap(bx, by, SPRING_X, SPRING_Y, SPRING_X + SPRING_WIDTH, SCREEN_HEIGHT);
		if (mObs) begin
			mEdge = nearestSide(bx, by, OBSTACLE_X, OBSTACLE_Y, OBSTACLE_X + OBSTACLE_SIZE,
				OBSTACLE_Y + OBSTACLE_SIZE);
		end
		else if (mSpr) begin
			mEdge = nearestSide(bx, by, SPRING_X, SPRING_Y, SPRING_X + SPRING_WIDTH,
				SCREEN_HEIGHT);
		end
		else begin
			mEdge = '0;
		end
		if (resetLevel) begin
			mPosX = BALL_INITIAL_X * FIXED_POINT_MULTIPLIER;
			mPosY = BALL_INITIAL_Y * FIXED_POINT_MULTIPLIER;
			mVx = 0;
			mVy = 0;
			mFx = FLIPPER_INITIAL_X;
			mFs = 0;
		end
		else if (!pause) begin
			if (startOfFrame) begin
				mPosX = mPosX + mVx;
				mPosY = mPosY + mVy;
				nextVy = mVy + GRAVITY;
				step = 0;
				if (flipperLeftKey && !flipperRightKey) begin
					step = (mFx < STEP) ? -mFx : -STEP;
				end
				else if (flipperRightKey && !flipperLeftKey) begin
					step = (SCREEN_WIDTH - FLIPPER_WIDTH - mFx < STEP) ?
						SCREEN_WIDTH - FLIPPER_WIDTH - mFx : STEP;
				end
				mFx = mFx + step;
				mFs = step * FIXED_POINT_MULTIPLIER;
			end
			mVx = nextVx;
			mVy = nextVy;
			launchCount += int'(launched);
		end
		// plunger
		if (mState == firing) begin
			mState = idle;
			mCharge = 0;
		end
		else if (startOfFrame && !pause) begin
			if (launchKey) begin
				mState = charging;
				mCharge = (mCharge < SPRING_MAX_CHARGE) ? mCharge + 1 : mCharge;
			end
			else if (mState == charging) begin
				mState = (mCharge > 0) ? firing : idle;
			end
		end
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
initial begin : stimulus
	int launchHold;
	logic pauseNext, levelNext, wasPaused;
	int heldX, heldY, heldFlipper;
	string phase;
	void'($urandom(91323));
	{pause, resetLevel, flipperLeftKey, flipperRightKey, launchKey} = '0;
	resetN = 1'b0;
	launchHold = 0;
	wasPaused = 1'b0;
	repeat (10) @(posedge clk);
	resetN <= 1'b1;
	for (int frame = 0; frame < TOTAL_FRAMES; frame++) begin
		waitFrame();
		if (timedOut) begin
			break;
		end
		@(posedge clk);
		pauseNext = 1'b0;
		levelNext = 1'b0;
		phase = "freeFall";
		if (frame >= FALL_FRAMES) begin
			phase = "random";
			pauseNext = ($urandom % 25) == 0;
			levelNext = !pauseNext && (($urandom % 40) == 0);
			if (launchHold > 0) begin
				launchHold--;
			end
			else if (($urandom % 8) == 0) begin
				launchHold = 1 + $urandom % 40;	// may pass the saturation limit
			end
			flipperLeftKey <= ($urandom % 3) == 0;
			flipperRightKey <= ($urandom % 3) == 0;
		end
		pause <= pauseNext;
		resetLevel <= levelNext;
		launchKey <= (launchHold > 0);
		@(negedge clk);
		compareValues({phase, " ball x"}, toPixel(mPosX), int'(ball.x));
		compareValues({phase, " ball y"}, toPixel(mPosY), int'(ball.y));
		compareValues({phase, " flipper x"}, mFx, int'(flipperX));
		if (wasPaused) begin
			compareValues("pause ball x", heldX, int'(ball.x));
			compareValues("pause ball y", heldY, int'(ball.y));
			compareValues("pause flipper x", heldFlipper, int'(flipperX));
		end
		if (levelNext) begin
			@(posedge clk);
			resetLevel <= 1'b0;
			@(negedge clk);
			compareValues("levelReset ball x", BALL_INITIAL_X, int'(ball.x));
			compareValues("levelReset ball y", BALL_INITIAL_Y, int'(ball.y));
			compareValues("levelReset flipper x", FLIPPER_INITIAL_X, int'(flipperX));
		end
		wasPaused = pauseNext;
		heldX = toPixel(mPosX);
		heldY = toPixel(mPosY);
		heldFlipper = mFx;
	end
	$display("checks %0d, errors %0d, spring launches %0d", checkCount, errorCount, launchCount);
	if (errorCount == 0) begin
		$display("No errors");
	end
	else begin
		$display("Errors found");
	end
	$finish;
end

endmodule

// File: run.sh
#!/bin/sh
# Build the pinball testbench with Verilator, run it, and search the log for failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pinballTb -f all.f -o pinballSim > build.log 2>&1 \
	&& ./obj_dir/pinballSim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Errors found" sim.log \
	&& { echo "FAIL"; exit 1; } \
	|| { echo "PASS"; exit 0; }

// File: source/ballController.sv
`timescale 1ns/1ns

module ballController import pinballGeomPkg::*, pinballTypesPkg::*; #(
	parameter int GRAVITY = 8
) (
	input	logic			clk,
	input	logic			resetN,
	input	logic			startOfFrame,
	input	logic			pause,
	input	logic			resetLevel,
	input	logic			springPulse,
	input	collisionFlags	hits,
	input	fixedSpeed		flipperSpeedX,
	input	fixedSpeed		springSpeedY,
	output	ballPos			ball
);

localparam int START_X = BALL_INITIAL_X * FIXED_POINT_MULTIPLIER;
localparam int START_Y = BALL_INITIAL_Y * FIXED_POINT_MULTIPLIER;

fixedSpeed speedX;
fixedSpeed speedY;
int posX;	// fixed point
int posY;

logic surface;
logic hitTop;
logic hitBottom;
logic hitLeft;
logic hitRight;
logic launch;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// contact sides
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
assign surface = hits.obstacle || hits.spring;	// sided objects
assign hitTop = hits.borderTop || (surface && hits.hitEdge[2]);
assign hitBottom = hits.flipper || (surface && hits.hitEdge[0]);
assign hitLeft = hits.borderLeft || (surface && hits.hitEdge[3]);
assign hitRight = hits.borderRight || (surface && hits.hitEdge[1]);
assign launch = springPulse && hits.spring && hits.hitEdge[0];	// resting on the cap

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vertical axis
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		speedY <= '0;
		posY <= START_Y;
	end
	else if (resetLevel) begin
		speedY <= '0;
		posY <= START_Y;
	end
	else if (!pause) begin
		if ((hitTop && (speedY < 0)) || (hitBottom && (speedY > 0))) begin
			speedY <= -speedY;	// moving into the surface
		end
		else if (launch) begin
			speedY <= speedY + springSpeedY;
		end
		// frame step uses the speed held before the edge
		if (startOfFrame) begin
			posY <= posY + speedY;
			speedY <= speedY + GRAVITY;
		end
	end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// horizontal axis
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		speedX <= '0;
		posX <= START_X;
	end
	else if (resetLevel) begin
		speedX <= '0;
		posX <= START_X;
	end
	else if (!pause) begin
		if ((hitLeft && (speedX < 0)) || (hitRight && (speedX > 0))) begin
			speedX <= -speedX;
		end
		else if (hits.flipper && (speedY > 0)) begin
			speedX <= speedX + flipperSpeedX;	// flipper kick
		end
		if (startOfFrame) begin
			posX <= posX + speedX;
		end
	end
end

assign ball.x = pixelCoord'(posX / FIXED_POINT_MULTIPLIER);
assign ball.y = pixelCoord'(posY / FIXED_POINT_MULTIPLIER);

endmodule

// File: source/collisionDetector.sv
`timescale 1ns/1ns

module collisionDetector import pinballGeomPkg::*, pinballTypesPkg::*; (
	input	logic			clk,
	input	logic			resetN,
	input	ballPos			ball,
	input	pixelCoord		flipperX,
	output	collisionFlags	hits
);

localparam int OBSTACLE_RIGHT = OBSTACLE_X + OBSTACLE_SIZE;
localparam int OBSTACLE_BOTTOM = OBSTACLE_Y + OBSTACLE_SIZE;
localparam int SPRING_RIGHT = SPRING_X + SPRING_WIDTH;
localparam int FLIPPER_BOTTOM = FLIPPER_Y + FLIPPER_HEIGHT;

int ballLeft;
int ballTop;
int ballRight;
int ballBottom;
int flipperLeft;
collisionFlags nextHits;

assign ballLeft = int'(ball.x);
assign ballTop = int'(ball.y);
assign ballRight = ballLeft + BALL_SIZE;	// exclusive
assign ballBottom = ballTop + BALL_SIZE;
assign flipperLeft = int'(flipperX);

// overlap of the ball box with a box, right and bottom exclusive
function automatic logic hitsBox(input int left, input int top, input int right,
		input int bottom);
	return (ballLeft < right) && (left < ballRight) && (ballTop < bottom) && (top < ballBottom);
endfunction

// side of the ball with the shallowest penetration
function automatic logic [3:0] touchingSide(input int depthBottom, input int depthRight,
		input int depthTop, input int depthLeft);
	logic [3:0] side;
	int best;
	side = 4'b0001;
	best = depthBottom;
	if (depthRight < best) begin
		side = 4'b0010;
		best = depthRight;
	end
	if (depthTop < best) begin
		side = 4'b0100;
		best = depthTop;
	end
	if (depthLeft < best) begin
		side = 4'b1000;
	end
	return side;
endfunction

always_comb begin
	nextHits = '0;
	nextHits.borderTop = (ballTop <= 0);
	nextHits.borderLeft = (ballLeft <= 0);
	nextHits.borderRight = (ballRight >= SCREEN_WIDTH);
	nextHits.flipper = hitsBox(flipperLeft, FLIPPER_Y, flipperLeft + FLIPPER_WIDTH,
		FLIPPER_BOTTOM);
	nextHits.obstacle = hitsBox(OBSTACLE_X, OBSTACLE_Y, OBSTACLE_RIGHT, OBSTACLE_BOTTOM);
	nextHits.spring = hitsBox(SPRING_X, SPRING_Y, SPRING_RIGHT, SCREEN_HEIGHT);
	if (nextHits.obstacle) begin
		nextHits.hitEdge = touchingSide(ballBottom - OBSTACLE_Y, ballRight - OBSTACLE_X,
			OBSTACLE_BOTTOM - ballTop, OBSTACLE_RIGHT - ballLeft);
	end
	else if (nextHits.spring) begin
		nextHits.hitEdge = touchingSide(ballBottom - SPRING_Y, ballRight - SPRING_X,
			SCREEN_HEIGHT - ballTop, SPRING_RIGHT - ballLeft);
	end
end

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		hits <= '0;
	end
	else begin
		hits <= nextHits;	// one cycle behind the positions
	end
end

endmodule

// File: source/flipperController.sv
`timescale 1ns/1ns

module flipperController import pinballGeomPkg::*, pinballTypesPkg::*; #(
	parameter int FLIPPER_STEP = 6
) (
	input	logic		clk,
	input	logic		resetN,
	input	logic		startOfFrame,
	input	logic		pause,
	input	logic		resetLevel,
	input	logic		leftKey,
	input	logic		rightKey,
	output	pixelCoord	flipperX,
	output	fixedSpeed	flipperSpeedX
);

localparam pixelCoord STEP = pixelCoord'(FLIPPER_STEP);
localparam pixelCoord RIGHT_LIMIT = pixelCoord'(SCREEN_WIDTH - FLIPPER_WIDTH);
localparam pixelCoord HOME_X = pixelCoord'(FLIPPER_INITIAL_X);

pixelCoord target;
fixedSpeed moveSpeed;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// next position, clamped to the screen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_comb begin
	target = flipperX;	// both keys or none
	if (leftKey && !rightKey) begin
		if (flipperX >= STEP) begin
			target = flipperX - STEP;
		end
		else begin
			target = '0;
		end
	end
	else if (rightKey && !leftKey) begin
		if (flipperX <= RIGHT_LIMIT - STEP) begin
			target = flipperX + STEP;
		end
		else begin
			target = RIGHT_LIMIT;
		end
	end
end

// zero when blocked by the edge
assign moveSpeed = fixedSpeed'(target - flipperX) * FIXED_POINT_MULTIPLIER;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		flipperX <= HOME_X;
		flipperSpeedX <= '0;
	end
	else if (resetLevel) begin
		flipperX <= HOME_X;
		flipperSpeedX <= '0;
	end
	else if (startOfFrame && !pause) begin
		flipperX <= target;
		flipperSpeedX <= moveSpeed;	// motion of this frame
	end
end

endmodule

// File: source/frameTicker.sv
`timescale 1ns/1ns

module frameTicker #(
	parameter int FRAME_CYCLES = 800000
) (
	input	logic	clk,
	input	logic	resetN,
	output	logic	startOfFrame
);

localparam int COUNT_BITS = $clog2(FRAME_CYCLES);
localparam logic [COUNT_BITS-1:0] LAST_COUNT = COUNT_BITS'(FRAME_CYCLES - 1);
localparam logic [COUNT_BITS-1:0] COUNT_STEP = COUNT_BITS'(1);

logic [COUNT_BITS-1:0] count;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		count <= '0;
	end
	else begin
		if (count == LAST_COUNT) begin
			count <= '0;	// wrap
		end
		else begin
			count <= count + COUNT_STEP;
		end
	end
end

assign startOfFrame = (count == LAST_COUNT);	// one cycle per frame

endmodule

// File: source/pinballGeomPkg.sv
package pinballGeomPkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// screen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam int SCREEN_WIDTH = 640;
localparam int SCREEN_HEIGHT = 480;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ball
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam int BALL_SIZE = 16;	// square box side
localparam int BALL_INITIAL_X = 300;
localparam int BALL_INITIAL_Y = 100;

localparam int FIXED_POINT_MULTIPLIER = 64;	// 6 fraction bits

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// playfield objects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
localparam int FLIPPER_Y = 420;	// top of the bar
localparam int FLIPPER_WIDTH = 96;
localparam int FLIPPER_HEIGHT = 8;
localparam int FLIPPER_INITIAL_X = (SCREEN_WIDTH - FLIPPER_WIDTH) / 2;

localparam int OBSTACLE_X = 160;
localparam int OBSTACLE_Y = 200;
localparam int OBSTACLE_SIZE = 48;

// The plunger cap reaches from SPRING_Y down to the bottom of the screen.
localparam int SPRING_X = 600;
localparam int SPRING_Y = 440;
localparam int SPRING_WIDTH = 32;

localparam int SPRING_MAX_CHARGE = 30;	// frames
localparam int SPRING_GAIN = 16;	// fixed point per charge frame

endpackage

// File: source/pinballTop.sv
`timescale 1ns/1ns

module pinballTop import pinballTypesPkg::*; #(
	parameter int FRAME_CYCLES = 800000,
	parameter int GRAVITY = 8,
	parameter int FLIPPER_STEP = 6
) (
	input	logic		clk,
	input	logic		resetN,
	input	logic		pause,
	input	logic		resetLevel,
	input	logic		flipperLeftKey,
	input	logic		flipperRightKey,
	input	logic		launchKey,
	output	ballPos		ball,
	output	pixelCoord	flipperX,
	output	logic		startOfFrame
);

fixedSpeed flipperSpeedX;
fixedSpeed springSpeedY;
logic springPulse;
collisionFlags hits;

frameTicker #(
	.FRAME_CYCLES(FRAME_CYCLES)
) ticker (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame)
);

flipperController #(
	.FLIPPER_STEP(FLIPPER_STEP)
) flipper (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.pause(pause),
	.resetLevel(resetLevel),
	.leftKey(flipperLeftKey),
	.rightKey(flipperRightKey),
	.flipperX(flipperX),
	.flipperSpeedX(flipperSpeedX)
);

springPlunger plunger (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.pause(pause),
	.launchKey(launchKey),
	.springPulse(springPulse),
	.springSpeedY(springSpeedY)
);

collisionDetector collisions (
	.clk(clk),
	.resetN(resetN),
	.ball(ball),
	.flipperX(flipperX),
	.hits(hits)
);

ballController #(
	.GRAVITY(GRAVITY)
) ballCtrl (
	.clk(clk),
	.resetN(resetN),
	.startOfFrame(startOfFrame),
	.pause(pause),
	.resetLevel(resetLevel),
	.springPulse(springPulse),
	.hits(hits),
	.flipperSpeedX(flipperSpeedX),
	.springSpeedY(springSpeedY),
	.ball(ball)
);

endmodule

// File: source/pinballTypesPkg.sv
package pinballTypesPkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
typedef logic signed [10:0] pixelCoord;	// screen pixels
typedef logic signed [31:0] fixedSpeed;	// pixels per frame, fixed point

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
typedef struct packed {
	pixelCoord x;	// top left corner
	pixelCoord y;
} ballPos;

typedef struct packed {
	logic borderTop;
	logic borderLeft;
	logic borderRight;
	logic flipper;
	logic obstacle;
	logic spring;
	logic [3:0] hitEdge;	// ball side: 0 bottom, 1 right, 2 top, 3 left
} collisionFlags;

typedef enum logic [1:0] {
	idle,
	charging,
	firing
} plungerState;

endpackage

// File: source/springPlunger.sv
`timescale 1ns/1ns

module springPlunger import pinballGeomPkg::*, pinballTypesPkg::*; (
	input	logic		clk,
	input	logic		resetN,
	input	logic		startOfFrame,
	input	logic		pause,
	input	logic		launchKey,
	output	logic		springPulse,
	output	fixedSpeed	springSpeedY
);

localparam int CHARGE_BITS = $clog2(SPRING_MAX_CHARGE + 1);
localparam logic [CHARGE_BITS-1:0] FULL_CHARGE = CHARGE_BITS'(SPRING_MAX_CHARGE);
localparam logic [CHARGE_BITS-1:0] ONE_FRAME = CHARGE_BITS'(1);

plungerState state;
logic [CHARGE_BITS-1:0] charge;	// frames held
logic frameTick;

assign frameTick = startOfFrame && !pause;

always_ff @(posedge clk or negedge resetN) begin
	if (!resetN) begin
		state <= idle;
		charge <= '0;
	end
	else begin
		case (state)
			idle: begin
				if (frameTick && launchKey) begin
					state <= charging;
					charge <= ONE_FRAME;
				end
			end
			charging: begin
				if (frameTick) begin
					if (launchKey) begin
						if (charge != FULL_CHARGE) begin
							charge <= charge + ONE_FRAME;	// saturate
						end
					end
					else begin
						state <= firing;	// charge is at least one here
					end
				end
			end
			firing: begin
				state <= idle;	// single pulse
				charge <= '0;
			end
			default: begin
				state <= idle;
			end
		endcase
	end
end

assign springPulse = (state == firing);
assign springSpeedY = springPulse ? -(fixedSpeed'(charge) * SPRING_GAIN) : '0;	// upward

endmodule
